// File: src.f
+incdir+source
source/tl_pkg.sv
source/xbar_pkg.sv
source/tl_ul_if.sv
source/tl_host_arbiter.sv
source/tl_device_demux.sv
source/tl_xbar_top.sv
dv/tl_xbar_tb.sv

// File: Makefile
# Verilator build and run for the TL-UL crossbar testbench

VERILATOR ?= verilator
TOP       ?= tl_xbar_tb
RTL_TOP   ?= tl_xbar_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log is searched for the fail message to decide the result
run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tl_xbar_tb.sv
//--------------------------------------
// Crossbar testbench with device memory
// models, compare tasks and a watchdog
//--------------------------------------
`timescale 1ns/1ps
`include "xbar_params.svh"

module tl_xbar_tb
  import tl_pkg::*;
  import xbar_pkg::*;
();

  localparam int NUM_STEPS = 16;
  localparam int DENIED    = `NUM_DEVICES;
  localparam int SEED      = 33584;

  // Word accesses, log2 of 4 bytes
  localparam tl_size_t WORD_SIZE = 2'd2;

  // With with_next set a row is issued together with the next one
  typedef struct {
    host_idx_t       host;
    tl_a_op_e        op;
    tl_addr_t        addr;
    tl_data_t        data;
    tl_mask_t        mask;
    tl_host_source_t src;
    int              exp_dev;
    tl_data_t        exp_data;
    logic            with_next;
  } step_t;

  // Request as it arrived at a device
  typedef struct {
    int              dev;
    tl_xbar_source_t src;
    tl_a_op_e        op;
    tl_size_t        size;
  } seen_t;

  logic            clk_i;
  logic            rst_i;

  logic            host_a_valid_i   [`NUM_HOSTS-1:0];
  logic            host_a_ready_o   [`NUM_HOSTS-1:0];
  tl_a_op_e        host_a_opcode_i  [`NUM_HOSTS-1:0];
  tl_size_t        host_a_size_i    [`NUM_HOSTS-1:0];
  tl_host_source_t host_a_source_i  [`NUM_HOSTS-1:0];
  tl_addr_t        host_a_address_i [`NUM_HOSTS-1:0];
  tl_mask_t        host_a_mask_i    [`NUM_HOSTS-1:0];
  tl_data_t        host_a_data_i    [`NUM_HOSTS-1:0];
  logic            host_d_valid_o   [`NUM_HOSTS-1:0];
  logic            host_d_ready_i   [`NUM_HOSTS-1:0] = '{default: 1'b0};
  tl_d_op_e        host_d_opcode_o  [`NUM_HOSTS-1:0];
  tl_host_source_t host_d_source_o  [`NUM_HOSTS-1:0];
  logic            host_d_denied_o  [`NUM_HOSTS-1:0];
  tl_data_t        host_d_data_o    [`NUM_HOSTS-1:0];

  logic            dev_a_valid_o    [`NUM_DEVICES-1:0];
  logic            dev_a_ready_i    [`NUM_DEVICES-1:0] = '{default: 1'b0};
  tl_a_op_e        dev_a_opcode_o   [`NUM_DEVICES-1:0];
  tl_size_t        dev_a_size_o     [`NUM_DEVICES-1:0];
  tl_xbar_source_t dev_a_source_o   [`NUM_DEVICES-1:0];
  tl_addr_t        dev_a_address_o  [`NUM_DEVICES-1:0];
  tl_mask_t        dev_a_mask_o     [`NUM_DEVICES-1:0];
  tl_data_t        dev_a_data_o     [`NUM_DEVICES-1:0];
  logic            dev_d_valid_i    [`NUM_DEVICES-1:0] = '{default: 1'b0};
  logic            dev_d_ready_o    [`NUM_DEVICES-1:0];
  tl_d_op_e        dev_d_opcode_i   [`NUM_DEVICES-1:0] = '{default: AccessAck};
  tl_xbar_source_t dev_d_source_i   [`NUM_DEVICES-1:0] = '{default: '0};
  logic            dev_d_denied_i   [`NUM_DEVICES-1:0] = '{default: 1'b0};
  tl_data_t        dev_d_data_i     [`NUM_DEVICES-1:0] = '{default: '0};

  step_t           steps [NUM_STEPS];
  seen_t           seen [$];
  tl_data_t        mem [tl_addr_t];
  logic            busy [`NUM_DEVICES];
  int              wait_cnt [`NUM_DEVICES];
  int              rdy_span [`NUM_HOSTS];
  int              issued [`NUM_HOSTS];
  int              resp_count [`NUM_HOSTS];
  logic            held [`NUM_HOSTS];
  tl_d_op_e        held_op [`NUM_HOSTS];
  tl_host_source_t held_src [`NUM_HOSTS];
  logic            held_denied [`NUM_HOSTS];
  tl_data_t        held_data [`NUM_HOSTS];
  int              err_count;
  int              check_count;

  tl_xbar_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic check_data(input string name, input tl_data_t got, input tl_data_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_source(input string name, input tl_host_source_t got,
                              input tl_host_source_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_xsource(input string name, input tl_xbar_source_t got,
                               input tl_xbar_source_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_opcode(input string name, input tl_d_op_e got, input tl_d_op_e exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_a_opcode(input string name, input tl_a_op_e got, input tl_a_op_e exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_size(input string name, input tl_size_t got, input tl_size_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Host, opcode, address, data, mask, source, device, read data, paired
  task automatic load_steps();
    steps[0]  = '{1'b0, PutFullData,    32'h1000_0010, 32'h1122_3344, 4'hF, 4'h1, 0, '0, 1'b0};
    steps[1]  = '{1'b0, Get,            32'h1000_0010, '0, 4'hF, 4'h2, 0, 32'h1122_3344, 1'b0};
    steps[2]  = '{1'b0, PutPartialData, 32'h1000_0010, 32'hAABB_CCDD, 4'h5, 4'h3, 0, '0, 1'b0};
    // Bytes 0 and 2 replaced by the partial write
    steps[3]  = '{1'b0, Get,            32'h1000_0010, '0, 4'hF, 4'h4, 0, 32'h11BB_33DD, 1'b0};
    steps[4]  = '{1'b1, PutFullData,    32'h2000_0100, 32'hCAFE_F00D, 4'hF, 4'h5, 1, '0, 1'b0};
    steps[5]  = '{1'b1, Get,            32'h2000_0100, '0, 4'hF, 4'h6, 1, 32'hCAFE_F00D, 1'b0};
    steps[6]  = '{1'b0, Get,            32'h0000_1000, '0, 4'hF, 4'h7, DENIED, '0, 1'b0};
    steps[7]  = '{1'b1, PutFullData,    32'h0000_1000, 32'hDEAD_BEEF, 4'hF, 4'h8, DENIED, '0, 1'b0};
    steps[8]  = '{1'b0, PutFullData,    32'h1000_0020, 32'h0102_0304, 4'hF, 4'h9, 0, '0, 1'b1};
    steps[9]  = '{1'b1, PutFullData,    32'h2000_0020, 32'h0506_0708, 4'hF, 4'hA, 1, '0, 1'b0};
    steps[10] = '{1'b0, Get,            32'h1000_0020, '0, 4'hF, 4'hB, 0, 32'h0102_0304, 1'b1};
    steps[11] = '{1'b1, Get,            32'h2000_0020, '0, 4'hF, 4'hC, 1, 32'h0506_0708, 1'b0};
    steps[12] = '{1'b0, Get,            32'h2000_0100, '0, 4'hF, 4'hD, 1, 32'hCAFE_F00D, 1'b1};
    steps[13] = '{1'b1, Get,            32'h0000_1000, '0, 4'hF, 4'hE, DENIED, '0, 1'b0};
    steps[14] = '{1'b1, Get,            32'h1000_0010, '0, 4'hF, 4'hF, 0, 32'h11BB_33DD, 1'b1};
    steps[15] = '{1'b0, Get,            32'h0000_1000, '0, 4'hF, 4'h0, DENIED, '0, 1'b0};
  endtask

  // Issue one row on its host and check the response it gets back
  task automatic run_step(input int i);
    step_t    s;
    int       h;
    tl_d_op_e exp_op;
    s      = steps[i];
    h      = int'(s.host);
    exp_op = (s.op == Get) ? AccessAckData : AccessAck;
    host_a_valid_i[h]   <= 1'b1;
    host_a_opcode_i[h]  <= s.op;
    host_a_size_i[h]    <= WORD_SIZE;
    host_a_source_i[h]  <= s.src;
    host_a_address_i[h] <= s.addr;
    host_a_mask_i[h]    <= s.mask;
    host_a_data_i[h]    <= s.data;
    do begin
      @(posedge clk_i);
    end while (!host_a_ready_o[h]);
    host_a_valid_i[h] <= 1'b0;
    issued[h]++;
    do begin
      @(posedge clk_i);
    end while (!(host_d_valid_o[h] && host_d_ready_i[h]));
    check_opcode($sformatf("host_d_opcode_o[%0d]", h), host_d_opcode_o[h], exp_op);
    check_source($sformatf("host_d_source_o[%0d]", h), host_d_source_o[h], s.src);
    check_bit($sformatf("host_d_denied_o[%0d]", h), host_d_denied_o[h], s.exp_dev == DENIED);
    if (s.op == Get || s.exp_dev == DENIED) begin
      check_data($sformatf("host_d_data_o[%0d]", h), host_d_data_o[h], s.exp_data);
    end
  endtask

  // Each mapped row must reach its device once with the widened source
  task automatic check_routing(input int first, input int n);
    int              pos;
    tl_xbar_source_t exp_src;
    for (int k = first; k < first + n; k++) begin
      if (steps[k].exp_dev != DENIED) begin
        exp_src = {steps[k].host, steps[k].src};
        pos     = -1;
        foreach (seen[q]) begin
          if (pos < 0 && seen[q].dev == steps[k].exp_dev) begin
            pos = q;
          end
        end
        if (pos < 0) begin
          err_count++;
          $display("Step %0d never reached device %0d", k, steps[k].exp_dev);
        end else begin
          check_xsource($sformatf("dev_a_source_o[%0d]", steps[k].exp_dev),
                        seen[pos].src, exp_src);
          check_a_opcode($sformatf("dev_a_opcode_o[%0d]", steps[k].exp_dev),
                         seen[pos].op, steps[k].op);
          check_size($sformatf("dev_a_size_o[%0d]", steps[k].exp_dev),
                     seen[pos].size, WORD_SIZE);
          seen.delete(pos);
        end
      end
    end
    while (seen.size() > 0) begin
      err_count++;
      $display("Request with source 0x%0h reached device %0d without being routed there",
               seen[0].src, seen[0].dev);
      seen.delete(0);
    end
  endtask

  // Device memory models with random response delay and ready gaps
  always @(posedge clk_i) begin : dev_model
    tl_data_t word;
    tl_addr_t addr;
    if (rst_i) begin
      for (int j = 0; j < `NUM_DEVICES; j++) begin
        busy[j] = 1'b0;
        dev_a_ready_i[j] <= 1'b0;
        dev_d_valid_i[j] <= 1'b0;
      end
    end else begin
      for (int j = 0; j < `NUM_DEVICES; j++) begin
        if (dev_d_valid_i[j] && dev_d_ready_o[j]) begin
          dev_d_valid_i[j] <= 1'b0;
          busy[j] = 1'b0;
        end else if (busy[j] && !dev_d_valid_i[j]) begin
          if (wait_cnt[j] == 0) begin
            dev_d_valid_i[j] <= 1'b1;
          end else begin
            wait_cnt[j]--;
          end
        end
        if (dev_a_valid_o[j] && dev_a_ready_i[j]) begin
          addr = dev_a_address_o[j];
          word = mem.exists(addr) ? mem[addr] : '0;
          seen.push_back('{j, dev_a_source_o[j], dev_a_opcode_o[j], dev_a_size_o[j]});
          if (dev_a_opcode_o[j] == Get) begin
            dev_d_opcode_i[j] <= AccessAckData;
            dev_d_data_i[j]   <= word;
          end else begin
            // Only bytes with their mask bit set are written
            for (int b = 0; b < `MASK_W; b++) begin
              if (dev_a_mask_o[j][b]) begin
                word[8*b +: 8] = dev_a_data_o[j][8*b +: 8];
              end
            end
            mem[addr] = word;
            dev_d_opcode_i[j] <= AccessAck;
            dev_d_data_i[j]   <= '0;
          end
          dev_d_source_i[j] <= dev_a_source_o[j];
          dev_d_denied_i[j] <= 1'b0;
          dev_a_ready_i[j]  <= 1'b0;
          busy[j]     = 1'b1;
          wait_cnt[j] = $urandom % 4;
        end else begin
          dev_a_ready_i[j] <= !busy[j] && ($urandom % 4 != 0);
        end
      end
    end
  end

  // Host D ready held at random levels for random spans
  always @(posedge clk_i) begin : host_ready
    for (int h = 0; h < `NUM_HOSTS; h++) begin
      if (rdy_span[h] <= 0) begin
        host_d_ready_i[h] <= ($urandom % 3 != 0);
        rdy_span[h] = $urandom % 4;
      end else begin
        rdy_span[h]--;
      end
    end
  end

  // A stalled D beat must stay put, and every transfer is counted
  always @(posedge clk_i) begin : d_monitor
    for (int h = 0; h < `NUM_HOSTS; h++) begin
      if (rst_i) begin
        held[h] = 1'b0;
      end else begin
        if (held[h]) begin
          check_bit($sformatf("host_d_valid_o[%0d]", h), host_d_valid_o[h], 1'b1);
          check_opcode($sformatf("host_d_opcode_o[%0d]", h), host_d_opcode_o[h], held_op[h]);
          check_source($sformatf("host_d_source_o[%0d]", h), host_d_source_o[h], held_src[h]);
          check_bit($sformatf("host_d_denied_o[%0d]", h), host_d_denied_o[h], held_denied[h]);
          check_data($sformatf("host_d_data_o[%0d]", h), host_d_data_o[h], held_data[h]);
        end
        if (host_d_valid_o[h] && host_d_ready_i[h]) begin
          resp_count[h]++;
        end
        held[h]        = host_d_valid_o[h] && !host_d_ready_i[h];
        held_op[h]     = host_d_opcode_o[h];
        held_src[h]    = host_d_source_o[h];
        held_denied[h] = host_d_denied_o[h];
        held_data[h]   = host_d_data_o[h];
      end
    end
  end

  initial begin : watchdog
    repeat (NUM_STEPS * 50) @(posedge clk_i);
    $display("Run stopped by the watchdog after %0d cycles", NUM_STEPS * 50);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : main
    int idx;
    void'($urandom(SEED));
    err_count   = 0;
    check_count = 0;
    rst_i       = 1'b1;
    for (int h = 0; h < `NUM_HOSTS; h++) begin
      host_a_valid_i[h]   = 1'b0;
      host_a_opcode_i[h]  = Get;
      host_a_size_i[h]    = '0;
      host_a_source_i[h]  = '0;
      host_a_address_i[h] = '0;
      host_a_mask_i[h]    = '0;
      host_a_data_i[h]    = '0;
      issued[h]           = 0;
      resp_count[h]       = 0;
    end
    load_steps();
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;
    idx = 0;
    while (idx < NUM_STEPS) begin
      if (steps[idx].with_next) begin
        fork
          run_step(idx);
          run_step(idx + 1);
        join
        check_routing(idx, 2);
        idx += 2;
      end else begin
        run_step(idx);
        check_routing(idx, 1);
        idx += 1;
      end
    end
    // Room for a stray duplicate response to show up
    repeat (8) @(posedge clk_i);
    for (int h = 0; h < `NUM_HOSTS; h++) begin
      if (resp_count[h] != issued[h]) begin
        err_count++;
        $display("Error: host%0d response count = 0x%0h, expected 0x%0h",
                 h, resp_count[h], issued[h]);
      end
    end
    $display("Summary: %0d checks, %0d errors, responses %0d/%0d and %0d/%0d", check_count,
             err_count, resp_count[0], issued[0], resp_count[1], issued[1]);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: source/tl_xbar_top.sv
//--------------------------------------
// Two-host, two-device TL-UL crossbar
//--------------------------------------
`timescale 1ns/1ps
`include "xbar_params.svh"

module tl_xbar_top
  import tl_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,

  // Hosts
  input  logic            host_a_valid_i   [`NUM_HOSTS-1:0],
  output logic            host_a_ready_o   [`NUM_HOSTS-1:0],
  input  tl_a_op_e        host_a_opcode_i  [`NUM_HOSTS-1:0],
  input  tl_size_t        host_a_size_i    [`NUM_HOSTS-1:0],
  input  tl_host_source_t host_a_source_i  [`NUM_HOSTS-1:0],
  input  tl_addr_t        host_a_address_i [`NUM_HOSTS-1:0],
  input  tl_mask_t        host_a_mask_i    [`NUM_HOSTS-1:0],
  input  tl_data_t        host_a_data_i    [`NUM_HOSTS-1:0],

  output logic            host_d_valid_o   [`NUM_HOSTS-1:0],
  input  logic            host_d_ready_i   [`NUM_HOSTS-1:0],
  output tl_d_op_e        host_d_opcode_o  [`NUM_HOSTS-1:0],
  output tl_host_source_t host_d_source_o  [`NUM_HOSTS-1:0],
  output logic            host_d_denied_o  [`NUM_HOSTS-1:0],
  output tl_data_t        host_d_data_o    [`NUM_HOSTS-1:0],

  // Devices
  output logic            dev_a_valid_o    [`NUM_DEVICES-1:0],
  input  logic            dev_a_ready_i    [`NUM_DEVICES-1:0],
  output tl_a_op_e        dev_a_opcode_o   [`NUM_DEVICES-1:0],
  output tl_size_t        dev_a_size_o     [`NUM_DEVICES-1:0],
  output tl_xbar_source_t dev_a_source_o   [`NUM_DEVICES-1:0],
  output tl_addr_t        dev_a_address_o  [`NUM_DEVICES-1:0],
  output tl_mask_t        dev_a_mask_o     [`NUM_DEVICES-1:0],
  output tl_data_t        dev_a_data_o     [`NUM_DEVICES-1:0],

  input  logic            dev_d_valid_i    [`NUM_DEVICES-1:0],
  output logic            dev_d_ready_o    [`NUM_DEVICES-1:0],
  input  tl_d_op_e        dev_d_opcode_i   [`NUM_DEVICES-1:0],
  input  tl_xbar_source_t dev_d_source_i   [`NUM_DEVICES-1:0],
  input  logic            dev_d_denied_i   [`NUM_DEVICES-1:0],
  input  tl_data_t        dev_d_data_i     [`NUM_DEVICES-1:0]
);

  // Single internal link between the two halves
  tl_ul_if link ();

  tl_host_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .h_a_valid_i   (host_a_valid_i),
    .h_a_ready_o   (host_a_ready_o),
    .h_a_opcode_i  (host_a_opcode_i),
    .h_a_size_i    (host_a_size_i),
    .h_a_source_i  (host_a_source_i),
    .h_a_address_i (host_a_address_i),
    .h_a_mask_i    (host_a_mask_i),
    .h_a_data_i    (host_a_data_i),
    .h_d_valid_o   (host_d_valid_o),
    .h_d_ready_i   (host_d_ready_i),
    .h_d_opcode_o  (host_d_opcode_o),
    .h_d_source_o  (host_d_source_o),
    .h_d_denied_o  (host_d_denied_o),
    .h_d_data_o    (host_d_data_o),
    .link          (link.host)
  );

  tl_device_demux u_demux (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .link          (link.device),
    .d_a_valid_o   (dev_a_valid_o),
    .d_a_ready_i   (dev_a_ready_i),
    .d_a_opcode_o  (dev_a_opcode_o),
    .d_a_size_o    (dev_a_size_o),
    .d_a_source_o  (dev_a_source_o),
    .d_a_address_o (dev_a_address_o),
    .d_a_mask_o    (dev_a_mask_o),
    .d_a_data_o    (dev_a_data_o),
    .d_d_valid_i   (dev_d_valid_i),
    .d_d_ready_o   (dev_d_ready_o),
    .d_d_opcode_i  (dev_d_opcode_i),
    .d_d_source_i  (dev_d_source_i),
    .d_d_denied_i  (dev_d_denied_i),
    .d_d_data_i    (dev_d_data_i)
  );

endmodule

// File: source/tl_device_demux.sv
//--------------------------------------
// Address decode to device links, D
// merge and denied responder
//--------------------------------------
`timescale 1ns/1ps
`include "xbar_params.svh"

module tl_device_demux
  import tl_pkg::*;
  import xbar_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,

  // Merged link from the arbiter
  tl_ul_if.device         link,

  // Device side, channel A
  output logic            d_a_valid_o   [`NUM_DEVICES-1:0],
  input  logic            d_a_ready_i   [`NUM_DEVICES-1:0],
  output tl_a_op_e        d_a_opcode_o  [`NUM_DEVICES-1:0],
  output tl_size_t        d_a_size_o    [`NUM_DEVICES-1:0],
  output tl_xbar_source_t d_a_source_o  [`NUM_DEVICES-1:0],
  output tl_addr_t        d_a_address_o [`NUM_DEVICES-1:0],
  output tl_mask_t        d_a_mask_o    [`NUM_DEVICES-1:0],
  output tl_data_t        d_a_data_o    [`NUM_DEVICES-1:0],

  // Device side, channel D
  input  logic            d_d_valid_i   [`NUM_DEVICES-1:0],
  output logic            d_d_ready_o   [`NUM_DEVICES-1:0],
  input  tl_d_op_e        d_d_opcode_i  [`NUM_DEVICES-1:0],
  input  tl_xbar_source_t d_d_source_i  [`NUM_DEVICES-1:0],
  input  logic            d_d_denied_i  [`NUM_DEVICES-1:0],
  input  tl_data_t        d_d_data_i    [`NUM_DEVICES-1:0]
);

  localparam tl_addr_t DEV_BASE [`NUM_DEVICES] = '{`DEV0_BASE, `DEV1_BASE};
  localparam tl_addr_t DEV_MASK [`NUM_DEVICES] = '{`DEV0_MASK, `DEV1_MASK};

  logic            a_hit;
  dev_idx_t        a_dev;

  err_state_e      err_state_q;
  tl_xbar_source_t err_source_q;
  tl_d_op_e        err_op_q;
  logic            err_valid;

  logic            pick_dev_valid;
  dev_idx_t        pick_dev;
  logic            hold_q;
  logic            hold_err_q;
  dev_idx_t        hold_dev_q;
  logic            use_err;
  dev_idx_t        use_dev;

  // Lowest device whose base matches the unmasked address bits
  always_comb begin
    a_hit = 1'b0;
    a_dev = '0;
    for (int unsigned j = 0; j < `NUM_DEVICES; j++) begin
      if (!a_hit && ((link.a_address & ~DEV_MASK[j]) == DEV_BASE[j])) begin
        a_hit = 1'b1;
        a_dev = dev_idx_t'(j);
      end
    end
  end

  // Responder takes a miss only when idle
  assign link.a_ready = a_hit ? d_a_ready_i[a_dev] : (err_state_q == ERR_IDLE);
  assign err_valid    = (err_state_q == ERR_RESP);

  for (genvar j = 0; j < `NUM_DEVICES; j++) begin : g_dev_a
    assign d_a_valid_o[j]   = link.a_valid && a_hit && (a_dev == dev_idx_t'(j));
    assign d_a_opcode_o[j]  = link.a_opcode;
    assign d_a_size_o[j]    = link.a_size;
    assign d_a_source_o[j]  = link.a_source;
    assign d_a_address_o[j] = link.a_address;
    assign d_a_mask_o[j]    = link.a_mask;
    assign d_a_data_o[j]    = link.a_data;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_state_q <= ERR_IDLE;
    end else begin
      case (err_state_q)
        ERR_IDLE: begin
          if (link.a_valid && !a_hit) begin
            err_state_q <= ERR_RESP;
          end
        end
        ERR_RESP: begin
          if (use_err && link.d_ready) begin
            err_state_q <= ERR_IDLE;
          end
        end
        default: err_state_q <= ERR_IDLE;
      endcase
    end
  end

  // Captured with the unmapped request
  always_ff @(posedge clk_i) begin
    if (err_state_q == ERR_IDLE && link.a_valid && !a_hit) begin
      err_source_q <= link.a_source;
      err_op_q     <= (link.a_opcode == Get) ? AccessAckData : AccessAck;
    end
  end

  // Fixed priority, responder before device 0 before device 1
  always_comb begin
    pick_dev_valid = 1'b0;
    pick_dev       = '0;
    for (int unsigned j = 0; j < `NUM_DEVICES; j++) begin
      if (!pick_dev_valid && d_d_valid_i[j]) begin
        pick_dev_valid = 1'b1;
        pick_dev       = dev_idx_t'(j);
      end
    end
  end

  // A stalled D beat keeps its winner so its fields stay put
  assign use_err = hold_q ? hold_err_q : err_valid;
  assign use_dev = hold_q ? hold_dev_q : pick_dev;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hold_q     <= 1'b0;
      hold_err_q <= 1'b0;
      hold_dev_q <= '0;
    end else begin
      hold_q     <= link.d_valid && !link.d_ready;
      hold_err_q <= use_err;
      hold_dev_q <= use_dev;
    end
  end

  assign link.d_valid  = use_err ? err_valid : d_d_valid_i[use_dev];
  assign link.d_opcode = use_err ? err_op_q : d_d_opcode_i[use_dev];
  assign link.d_source = use_err ? err_source_q : d_d_source_i[use_dev];
  assign link.d_denied = use_err ? 1'b1 : d_d_denied_i[use_dev];
  assign link.d_data   = use_err ? '0 : d_d_data_i[use_dev];

  for (genvar j = 0; j < `NUM_DEVICES; j++) begin : g_dev_d
    assign d_d_ready_o[j] = link.d_ready && !use_err && (use_dev == dev_idx_t'(j));
  end

endmodule

// File: source/tl_host_arbiter.sv
//--------------------------------------
// Round-robin merge of host A channels,
// D return by source prefix
//--------------------------------------
`timescale 1ns/1ps
`include "xbar_params.svh"

module tl_host_arbiter
  import tl_pkg::*;
  import xbar_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_i,

  // Host side, channel A
  input  logic            h_a_valid_i   [`NUM_HOSTS-1:0],
  output logic            h_a_ready_o   [`NUM_HOSTS-1:0],
  input  tl_a_op_e        h_a_opcode_i  [`NUM_HOSTS-1:0],
  input  tl_size_t        h_a_size_i    [`NUM_HOSTS-1:0],
  input  tl_host_source_t h_a_source_i  [`NUM_HOSTS-1:0],
  input  tl_addr_t        h_a_address_i [`NUM_HOSTS-1:0],
  input  tl_mask_t        h_a_mask_i    [`NUM_HOSTS-1:0],
  input  tl_data_t        h_a_data_i    [`NUM_HOSTS-1:0],

  // Host side, channel D
  output logic            h_d_valid_o   [`NUM_HOSTS-1:0],
  input  logic            h_d_ready_i   [`NUM_HOSTS-1:0],
  output tl_d_op_e        h_d_opcode_o  [`NUM_HOSTS-1:0],
  output tl_host_source_t h_d_source_o  [`NUM_HOSTS-1:0],
  output logic            h_d_denied_o  [`NUM_HOSTS-1:0],
  output tl_data_t        h_d_data_o    [`NUM_HOSTS-1:0],

  // Merged link toward the demux
  tl_ul_if.host           link
);

  host_idx_t ptr_q;
  host_idx_t lock_idx_q;
  logic      lock_q;
  host_idx_t pick_idx;
  host_idx_t gnt_idx;
  host_idx_t d_host;
  logic      a_fire;

  // First valid host at or after the pointer
  always_comb begin
    logic        found;
    int unsigned cand;
    found    = 1'b0;
    pick_idx = ptr_q;
    for (int unsigned k = 0; k < `NUM_HOSTS; k++) begin
      cand = (32'(ptr_q) + k) % `NUM_HOSTS;
      if (!found && h_a_valid_i[cand]) begin
        found    = 1'b1;
        pick_idx = host_idx_t'(cand);
      end
    end
  end

  // A stalled beat keeps its grant until it transfers
  assign gnt_idx = lock_q ? lock_idx_q : pick_idx;
  assign a_fire  = link.a_valid && link.a_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= link.a_valid && !link.a_ready;
      lock_idx_q <= gnt_idx;
      if (a_fire) begin
        // Next search starts just past the granted host
        if (32'(gnt_idx) == `NUM_HOSTS - 1) begin
          ptr_q <= '0;
        end else begin
          ptr_q <= gnt_idx + 1'b1;
        end
      end
    end
  end

  // Zero when no host is valid, since the pick then points at an idle host
  assign link.a_valid   = h_a_valid_i[gnt_idx];
  assign link.a_opcode  = h_a_opcode_i[gnt_idx];
  assign link.a_size    = h_a_size_i[gnt_idx];
  assign link.a_source  = {gnt_idx, h_a_source_i[gnt_idx]};
  assign link.a_address = h_a_address_i[gnt_idx];
  assign link.a_mask    = h_a_mask_i[gnt_idx];
  assign link.a_data    = h_a_data_i[gnt_idx];

  // Owning host sits in the top bits of the D source
  assign d_host       = host_idx_t'(link.d_source[`XBAR_SOURCE_W-1:`HOST_SOURCE_W]);
  assign link.d_ready = h_d_ready_i[d_host];

  for (genvar i = 0; i < `NUM_HOSTS; i++) begin : g_host
    assign h_a_ready_o[i]  = link.a_ready && (gnt_idx == host_idx_t'(i));
    assign h_d_valid_o[i]  = link.d_valid && (d_host == host_idx_t'(i));
    assign h_d_opcode_o[i] = link.d_opcode;
    assign h_d_source_o[i] = link.d_source[`HOST_SOURCE_W-1:0];
    assign h_d_denied_o[i] = link.d_denied;
    assign h_d_data_o[i]   = link.d_data;
  end

endmodule

// File: source/tl_ul_if.sv
//--------------------------------------
// One TL-UL link, channels A and D
//--------------------------------------
`timescale 1ns/1ps

interface tl_ul_if import tl_pkg::*; ();

  // Channel A, host to device
  logic            a_valid;
  logic            a_ready;
  tl_a_op_e        a_opcode;
  tl_size_t        a_size;
  tl_xbar_source_t a_source;
  tl_addr_t        a_address;
  tl_mask_t        a_mask;
  tl_data_t        a_data;

  // Channel D, device to host
  logic            d_valid;
  logic            d_ready;
  tl_d_op_e        d_opcode;
  tl_xbar_source_t d_source;
  logic            d_denied;
  tl_data_t        d_data;

  modport host (
    output a_valid, a_opcode, a_size, a_source, a_address, a_mask, a_data,
    input  a_ready,
    input  d_valid, d_opcode, d_source, d_denied, d_data,
    output d_ready
  );

  modport device (
    input  a_valid, a_opcode, a_size, a_source, a_address, a_mask, a_data,
    output a_ready,
    output d_valid, d_opcode, d_source, d_denied, d_data,
    input  d_ready
  );

endinterface

// File: source/xbar_pkg.sv
//--------------------------------------
// Crossbar link indices and error
// responder states
//--------------------------------------
`include "xbar_params.svh"

package xbar_pkg;

  // Host number, also the top bits of a widened source
  typedef logic [`HOST_IDX_W-1:0] host_idx_t;

  // Device link number
  typedef logic [`DEV_IDX_W-1:0] dev_idx_t;

  // Denied responder for unmapped addresses
  typedef enum logic {
    ERR_IDLE,
    ERR_RESP
  } err_state_e;

endpackage

// File: source/tl_pkg.sv
//--------------------------------------
// TileLink-UL opcodes and channel field
// types
//--------------------------------------
`include "xbar_params.svh"

package tl_pkg;

  // Channel A opcodes, TL-UL subset
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // Channel D opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // log2 of the byte count
  typedef logic [`SIZE_W-1:0] tl_size_t;

  typedef logic [`ADDR_W-1:0] tl_addr_t;
  typedef logic [`DATA_W-1:0] tl_data_t;
  typedef logic [`MASK_W-1:0] tl_mask_t;

  // Source ID at a host port
  typedef logic [`HOST_SOURCE_W-1:0] tl_host_source_t;

  // Source ID inside the crossbar and at the devices
  typedef logic [`XBAR_SOURCE_W-1:0] tl_xbar_source_t;

endpackage

// File: source/xbar_params.svh
//--------------------------------------
// Crossbar widths, link counts and the
// device address map
//--------------------------------------
`ifndef XBAR_PARAMS_SVH
`define XBAR_PARAMS_SVH

// Link counts and index widths
`define NUM_HOSTS     2
`define NUM_DEVICES   2
`define HOST_IDX_W    1
`define DEV_IDX_W     1

// Channel field widths
`define ADDR_W        32
`define DATA_W        32
`define MASK_W        (`DATA_W / 8)
`define SIZE_W        2
`define HOST_SOURCE_W 4
// Host source widened by the host index
`define XBAR_SOURCE_W (`HOST_SOURCE_W + `HOST_IDX_W)

// Address map, a device matches when the unmasked bits equal its base
`define DEV0_BASE     32'h1000_0000
`define DEV0_MASK     32'h0FFF_FFFF
`define DEV1_BASE     32'h2000_0000
`define DEV1_MASK     32'h0FFF_FFFF

`endif
